// File: src/isaPkg.sv
`default_nettype none

package isaPkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int wordW = 16;
	localparam int regW = 4;
	localparam int opW = 4;

	// datapath word and register index
	typedef logic [wordW-1:0] word;
	typedef logic [regW-1:0] regIdx;

	// r0 reads as zero, never a forwarding source
	localparam regIdx regZero = '0;

	////////////////////////////////////////
	// opcodes, instr[15:12]
	////////////////////////////////////////

	typedef enum logic [opW-1:0] {
		opAdd    = 4'h0,
		opSub    = 4'h1,
		opRed    = 4'h2,
		opXor    = 4'h3,
		opSll    = 4'h4,
		opSra    = 4'h5,
		opRor    = 4'h6,
		opPaddsb = 4'h7,
		opLw     = 4'h8,
		opSw     = 4'h9,
		opLhb    = 4'hA,
		opLlb    = 4'hB,
		opB      = 4'hC,
		opBr     = 4'hD,
		opPcs    = 4'hE,
		opHlt    = 4'hF
	} opcode;

	////////////////////////////////////////
	// pipeline boundaries
	////////////////////////////////////////

	// ID/EX entry, 66 bits
	typedef struct packed {
		word instr;
		word regData1;
		word regData2;
		word pcs;
		logic regWrite;
		logic valid;
	} idExBus;

	// writeback feedback, 21 bits
	typedef struct packed {
		word writeData;
		regIdx rd;
		logic regWrite;
	} memWbBus;

	// EX/MEM entry leaving the stage, 22 bits
	typedef struct packed {
		word aluOut;
		regIdx rd;
		logic regWrite;
		logic valid;
	} exMemBus;

endpackage

`default_nettype wire

// File: src/aluPkg.sv
`default_nettype none

package aluPkg;

	localparam int selW = 2;

	////////////////////////////////////////
	// alu control word
	////////////////////////////////////////

	// which unit drives the result
	typedef enum logic [selW-1:0] {
		selCla   = 2'd0,
		selXor   = 2'd1,
		selShift = 2'd2
	} outSel;

	// shifter mode, taken straight from instr[13:12]
	typedef enum logic [selW-1:0] {
		shSll = 2'd0,
		shSra = 2'd1,
		shRor = 2'd2
	} shiftOp;

	// 7-bit control word {outSel, sat, red, sub, shiftOp}
	typedef struct packed {
		outSel outSel;
		logic sat;
		logic red;
		logic sub;
		shiftOp shiftOp;
	} aluOp;

	////////////////////////////////////////
	// forwarding
	////////////////////////////////////////

	typedef enum logic [selW-1:0] {
		fwdNone    = 2'd0,
		fwdFromWb  = 2'd1,
		fwdFromMem = 2'd2
	} fwdSel;

	// source registers read by the instruction
	typedef struct packed {
		isaPkg::regIdx srcA;
		isaPkg::regIdx srcB;
	} srcRegs;

endpackage

`default_nettype wire

// File: src/aluControl.sv
`timescale 1ns/1ns
`default_nettype none

module aluControl (
	input  isaPkg::word    instr,
	input  isaPkg::word    regData1,
	input  isaPkg::word    regData2,
	input  isaPkg::word    pcs,
	input  isaPkg::word    aluOutMem,
	input  isaPkg::word    writeData,
	input  aluPkg::fwdSel  fwdA,
	input  aluPkg::fwdSel  fwdB,
	output aluPkg::srcRegs srcs,
	output isaPkg::word    aluA,
	output isaPkg::word    aluB,
	output aluPkg::aluOp   op
);

	isaPkg::opcode opc;
	logic bitA;
	logic bitB;
	logic bitC;
	logic bitD;

	// internal formatting controls
	logic useImm;
	logic byteSelect;
	logic pcsSelect;
	logic ldByte;
	logic memOp;

	isaPkg::word regA;
	isaPkg::word regB;
	isaPkg::word fmtA;
	isaPkg::word byteImm;
	isaPkg::word nibImm;
	isaPkg::word imm;

	// pick the freshest copy of a register
	function automatic isaPkg::word fwdMux(
		input aluPkg::fwdSel sel,
		input isaPkg::word fromReg
	);
		case (sel)
			aluPkg::fwdFromMem: return aluOutMem;
			aluPkg::fwdFromWb:  return writeData;
			default:            return fromReg;
		endcase
	endfunction

	assign opc = isaPkg::opcode'(instr[15:12]);
	assign {bitA, bitB, bitC, bitD} = instr[15:12];

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	// shifts, lw, sw, lhb, llb take an immediate
	// b and br also match but pcsSelect wins there
	assign useImm = (bitA & ~bitB) | (bitB & ~bitC) | (~bitA & bitB & ~bitD);
	// lhb/llb and lw/sw groups
	assign ldByte = (opc == isaPkg::opLhb) || (opc == isaPkg::opLlb);
	assign memOp = (opc == isaPkg::opLw) || (opc == isaPkg::opSw);
	// 1 means llb, low byte gets replaced
	assign byteSelect = bitD;
	// b, br, pcs, hlt
	assign pcsSelect = bitA & bitB;

	// paddsb, don't care outside the cla
	assign op.sat = ~bitA & bitB;
	assign op.red = ~bitA & ~bitB & bitC;
	assign op.sub = ~bitA & ~bitB & bitD;
	assign op.shiftOp = aluPkg::shiftOp'(instr[13:12]);
	// shifts -> 2, xor -> 1, everything else on the cla
	assign op.outSel = aluPkg::outSel'({~bitA & bitB & (~bitC | ~bitD),
		~bitA & ~bitB & bitC & bitD});

	// lhb/llb read rd as the byte merge source
	assign srcs.srcA = ldByte ? instr[11:8] : instr[7:4];
	assign srcs.srcB = instr[3:0];

	////////////////////////////////////////
	// operand A
	////////////////////////////////////////

	assign regA = fwdMux(fwdA, regData1);
	// keep the byte that the immediate does not overwrite
	assign fmtA = byteSelect ? {regA[15:8], 8'h00} : {8'h00, regA[7:0]};
	// pcs group adds pcs to zero
	assign aluA = pcsSelect ? '0 : (ldByte ? fmtA : regA);

	////////////////////////////////////////
	// operand B
	////////////////////////////////////////

	assign regB = fwdMux(fwdB, regData2);
	// byte immediate sits in the half that gets replaced
	assign byteImm = byteSelect ? {8'h00, instr[7:0]} : {instr[7:0], 8'h00};
	// lw/sw offsets count halfwords
	assign nibImm = memOp ? {{11{instr[3]}}, instr[3:0], 1'b0} : {{12{instr[3]}}, instr[3:0]};
	assign imm = ldByte ? byteImm : nibImm;
	assign aluB = pcsSelect ? pcs : (useImm ? imm : regB);

endmodule

`default_nettype wire

// File: src/forwardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module forwardUnit (
	input  logic            clk,
	input  logic            rst,
	input  isaPkg::idExBus  idEx,
	input  isaPkg::memWbBus memWb,
	input  aluPkg::srcRegs  srcs,
	output aluPkg::fwdSel   fwdA,
	output aluPkg::fwdSel   fwdB,
	output isaPkg::regIdx   exRd,
	output logic            exRegWrite,
	output logic            exValid
);

	logic memOk;
	logic wbOk;

	// EX/MEM beats MEM/WB, r0 never forwards
	function automatic aluPkg::fwdSel pickSrc(
		input isaPkg::regIdx src,
		input logic memHit,
		input isaPkg::regIdx memRd,
		input logic wbHit,
		input isaPkg::regIdx wbRd
	);
		if (memHit && (memRd == src))
			return aluPkg::fwdFromMem;
		else if (wbHit && (wbRd == src))
			return aluPkg::fwdFromWb;
		else
			return aluPkg::fwdNone;
	endfunction

	////////////////////////////////////////
	// EX/MEM destination
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		exRd <= idEx.instr[11:8];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exRegWrite <= 1'b0;
			exValid <= 1'b0;
		end else begin
			exRegWrite <= idEx.regWrite;
			exValid <= idEx.valid;
		end
	end

	// entries able to supply a value
	assign memOk = exValid && exRegWrite && (exRd != isaPkg::regZero);
	assign wbOk = memWb.regWrite && (memWb.rd != isaPkg::regZero);

	assign fwdA = pickSrc(srcs.srcA, memOk, exRd, wbOk, memWb.rd);
	assign fwdB = pickSrc(srcs.srcB, memOk, exRd, wbOk, memWb.rd);

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  logic         clk,
	input  logic         rst,
	input  isaPkg::word  a,
	input  isaPkg::word  b,
	input  aluPkg::aluOp op,
	output isaPkg::word  result
);

	isaPkg::word bEff;
	isaPkg::word rawSum;
	logic addOvf;
	isaPkg::word addSat;
	isaPkg::word nibSum;
	isaPkg::word redSum;
	isaPkg::word claOut;
	logic [3:0] shAmt;
	logic [31:0] rotPair;
	isaPkg::word shifted;
	isaPkg::word nextResult;

	////////////////////////////////////////
	// cla paths
	////////////////////////////////////////

	// sub is a + ~b + 1
	assign bEff = op.sub ? ~b : b;
	assign rawSum = a + bEff + {15'd0, op.sub};
	// same input signs, different result sign
	assign addOvf = (a[15] == bEff[15]) && (rawSum[15] != a[15]);
	assign addSat = addOvf ? (a[15] ? 16'h8000 : 16'h7fff) : rawSum;

	// paddsb, four nibble lanes with no carry between them
	for (genvar i = 0; i < 4; i++) begin : gNib
		logic [3:0] laneSum;
		logic laneOvf;

		assign laneSum = a[4*i +: 4] + b[4*i +: 4];
		assign laneOvf = (a[4*i+3] == b[4*i+3]) && (laneSum[3] != a[4*i+3]);
		// clamp to 8 or 7 by the lane's input sign
		assign nibSum[4*i +: 4] = laneOvf ? (a[4*i+3] ? 4'h8 : 4'h7) : laneSum;
	end

	// red, all four signed bytes summed at full width
	assign redSum = {{8{a[15]}}, a[15:8]}
		+ {{8{a[7]}}, a[7:0]}
		+ {{8{b[15]}}, b[15:8]}
		+ {{8{b[7]}}, b[7:0]};

	assign claOut = op.red ? redSum : (op.sat ? nibSum : addSat);

	////////////////////////////////////////
	// shifter
	////////////////////////////////////////

	assign shAmt = b[3:0];
	// rotate right through a doubled copy
	assign rotPair = {a, a} >> shAmt;

	always_comb begin
		case (op.shiftOp)
			aluPkg::shSll: shifted = a << shAmt;
			aluPkg::shSra: shifted = $signed(a) >>> shAmt;
			aluPkg::shRor: shifted = rotPair[15:0];
			default:       shifted = a;
		endcase
	end

	////////////////////////////////////////
	// result select, EX/MEM register
	////////////////////////////////////////

	always_comb begin
		case (op.outSel)
			aluPkg::selCla:   nextResult = claOut;
			aluPkg::selXor:   nextResult = a ^ b;
			aluPkg::selShift: nextResult = shifted;
			default:          nextResult = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
		end else begin
			result <= nextResult;
		end
	end

endmodule

`default_nettype wire

// File: src/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage (
	input  logic            clk,
	input  logic            rst,
	input  isaPkg::idExBus  idEx,
	input  isaPkg::memWbBus memWb,
	output isaPkg::exMemBus exMem
);

	aluPkg::srcRegs srcs;
	aluPkg::fwdSel fwdA;
	aluPkg::fwdSel fwdB;
	aluPkg::aluOp op;
	isaPkg::word aluA;
	isaPkg::word aluB;
	isaPkg::word aluOut;
	isaPkg::regIdx exRd;
	logic exRegWrite;
	logic exValid;

	// decode and operand formatting, EX/MEM result fed back as fromMem
	aluControl control0 (
		.instr     (idEx.instr),
		.regData1  (idEx.regData1),
		.regData2  (idEx.regData2),
		.pcs       (idEx.pcs),
		.aluOutMem (aluOut),
		.writeData (memWb.writeData),
		.fwdA      (fwdA),
		.fwdB      (fwdB),
		.srcs      (srcs),
		.aluA      (aluA),
		.aluB      (aluB),
		.op        (op)
	);

	// hazard compare plus the registered control half of EX/MEM
	forwardUnit forward0 (
		.clk        (clk),
		.rst        (rst),
		.idEx       (idEx),
		.memWb      (memWb),
		.srcs       (srcs),
		.fwdA       (fwdA),
		.fwdB       (fwdB),
		.exRd       (exRd),
		.exRegWrite (exRegWrite),
		.exValid    (exValid)
	);

	alu alu0 (
		.clk    (clk),
		.rst    (rst),
		.a      (aluA),
		.b      (aluB),
		.op     (op),
		.result (aluOut)
	);

	assign exMem = '{aluOut: aluOut, rd: exRd, regWrite: exRegWrite, valid: exValid};

endmodule

`default_nettype wire

// File: verification/executeStage_sva.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage_sva (
	input logic            clk,
	input logic            rst,
	input isaPkg::idExBus  idEx,
	input isaPkg::exMemBus exMem,
	input aluPkg::aluOp    op
);

	// control half of EX/MEM is cleared by reset
	resetClears: assert property (@(posedge clk) rst |=> !exMem.valid && !exMem.regWrite)
		else $error("exMem valid or regWrite set in the cycle after reset");

	// one cycle of latency, bubbles included
	validFollows: assert property (@(posedge clk) !rst |=> exMem.valid == $past(idEx.valid))
		else $error("exMem valid does not follow idEx valid of the previous cycle");

	// encoding 3 of the result select is never decoded
	outSelLegal: assert property (@(posedge clk) disable iff (rst)
		op.outSel inside {aluPkg::selCla, aluPkg::selXor, aluPkg::selShift})
		else $error("alu result select decoded to an unused value");

endmodule

bind executeStage executeStage_sva sva0 (
	.clk   (clk),
	.rst   (rst),
	.idEx  (idEx),
	.exMem (exMem),
	.op    (op)
);

`default_nettype wire

// File: verification/executeStageTb.sv
`timescale 1ns/1ns
`default_nettype none

module executeStageTb;

	localparam int randCount = 2000;
	localparam int runLimit = 3000;
	localparam int drainLimit = 8;
	localparam isaPkg::memWbBus noWb = '0;

	logic clk;
	logic rst;
	isaPkg::idExBus idEx;
	isaPkg::memWbBus memWb;
	isaPkg::exMemBus exMem;

	logic [31:0] lfsrState;
	// expected EX/MEM of the entry issued last, the fromMem source of the next one
	isaPkg::exMemBus prevExp;
	isaPkg::exMemBus expQ[$];
	string nameQ[$];
	int stampQ[$];
	int negCount;
	int errCount;

	executeStage dut0 (
		.clk   (clk),
		.rst   (rst),
		.idEx  (idEx),
		.memWb (memWb),
		.exMem (exMem)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	// 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] v;
		logic fb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			v = {v[14:0], fb};
		end
		return v;
	endfunction

	// half the time stay in r0..r3 so that hazards come up often
	function automatic isaPkg::regIdx pickReg();
		if (takeBits(1) != 16'd0)
			return 4'(takeBits(2));
		else
			return 4'(takeBits(4));
	endfunction

	function automatic isaPkg::word mkInstr(input isaPkg::opcode opc, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {opc, rd, rs, rt};
	endfunction

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// clamp to the signed range [-lim, lim-1]
	function automatic int satSum(input int s, input int lim);
		if (s > lim - 1)
			return lim - 1;
		else if (s < -lim)
			return -lim;
		else
			return s;
	endfunction

	// EX/MEM first, then writeback, r0 never
	function automatic isaPkg::word operand(input isaPkg::regIdx src, input isaPkg::word fileVal,
		input isaPkg::memWbBus wb, input isaPkg::exMemBus prev);
		if (prev.valid && prev.regWrite && prev.rd != 4'd0 && prev.rd == src)
			return prev.aluOut;
		else if (wb.regWrite && wb.rd != 4'd0 && wb.rd == src)
			return wb.writeData;
		else
			return fileVal;
	endfunction

	function automatic isaPkg::exMemBus refExecute(input isaPkg::idExBus id,
		input isaPkg::memWbBus wb, input isaPkg::exMemBus prev);
		logic [3:0] opc;
		logic [3:0] amt;
		isaPkg::regIdx srcA;
		isaPkg::word a;
		isaPkg::word b;
		isaPkg::word r;
		int imm;
		int w;
		int lane;
		isaPkg::exMemBus res;
		opc = id.instr[15:12];
		amt = id.instr[3:0];
		imm = int'($signed(id.instr[3:0]));
		// lhb and llb merge into the old value of rd
		srcA = (opc == 4'hA || opc == 4'hB) ? id.instr[11:8] : id.instr[7:4];
		a = operand(srcA, id.regData1, wb, prev);
		b = operand(id.instr[3:0], id.regData2, wb, prev);
		r = '0;
		case (opc)
			4'h0: r = 16'(satSum(int'($signed(a)) + int'($signed(b)), 32768));
			4'h1: r = 16'(satSum(int'($signed(a)) - int'($signed(b)), 32768));
			4'h2: r = 16'(int'($signed(a[15:8])) + int'($signed(a[7:0]))
				+ int'($signed(b[15:8])) + int'($signed(b[7:0])));
			4'h3: r = a ^ b;
			4'h4: r = a << amt;
			4'h5: r = $signed(a) >>> amt;
			4'h6: begin
				w = int'(a);
				r = 16'((w >> amt) | (w << (16 - int'(amt))));
			end
			4'h7: begin
				// four signed nibble lanes, each clamped on its own
				for (int i = 0; i < 4; i++) begin
					lane = satSum(int'($signed(a[4*i +: 4])) + int'($signed(b[4*i +: 4])), 8);
					r[4*i +: 4] = 4'(lane);
				end
			end
			// offset counts halfwords
			4'h8, 4'h9: r = 16'(satSum(int'($signed(a)) + 2 * imm, 32768));
			4'hA: r = {id.instr[7:0], a[7:0]};
			4'hB: r = {a[15:8], id.instr[7:0]};
			// b, br, pcs, hlt pass pcs through
			default: r = id.pcs;
		endcase
		res.aluOut = r;
		res.rd = id.instr[11:8];
		res.regWrite = id.regWrite;
		res.valid = id.valid;
		return res;
	endfunction

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	task automatic abortRun();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkWord(input string name, input isaPkg::word expv, input isaPkg::word act);
		if (act !== expv) begin
			errCount++;
			$display("mismatch %s: expected %h, actual %h", name, expv, act);
			abortRun();
		end
	endtask

	task automatic checkIdx(input string name, input isaPkg::regIdx expv,
		input isaPkg::regIdx act);
		if (act !== expv) begin
			errCount++;
			$display("mismatch %s: expected %h, actual %h", name, expv, act);
			abortRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic expv, input logic act);
		if (act !== expv) begin
			errCount++;
			$display("mismatch %s: expected %b, actual %b", name, expv, act);
			abortRun();
		end
	endtask

	task automatic compareEntry(input string name, input isaPkg::exMemBus expv);
		checkWord({name, " aluOut"}, expv.aluOut, exMem.aluOut);
		checkIdx({name, " rd"}, expv.rd, exMem.rd);
		checkFlag({name, " regWrite"}, expv.regWrite, exMem.regWrite);
		checkFlag({name, " valid"}, expv.valid, exMem.valid);
	endtask

	// an entry driven before negedge n is on exMem at negedge n+1
	initial begin
		negCount = 0;
		forever begin
			@(negedge clk);
			while (expQ.size() != 0 && stampQ[0] + 1 == negCount) begin
				compareEntry(nameQ[0], expQ[0]);
				void'(expQ.pop_front());
				void'(nameQ.pop_front());
				void'(stampQ.pop_front());
			end
			negCount++;
		end
	end

	initial begin
		for (int n = 0; n < runLimit; n++)
			@(posedge clk);
		$display("run did not finish within %0d cycles", runLimit);
		abortRun();
	end

	////////////////////////////////////////
	// drivers
	////////////////////////////////////////

	task automatic issue(input string name, input isaPkg::idExBus id, input isaPkg::memWbBus wb);
		isaPkg::exMemBus expv;
		@(posedge clk);
		idEx <= id;
		memWb <= wb;
		expv = refExecute(id, wb, prevExp);
		prevExp = expv;
		expQ.push_back(expv);
		nameQ.push_back(name);
		stampQ.push_back(negCount);
	endtask

	task automatic directed(input string name, input isaPkg::word instr, input isaPkg::word d1,
		input isaPkg::word d2, input isaPkg::word pcs, input isaPkg::memWbBus wb);
		isaPkg::idExBus id;
		id = '{instr: instr, regData1: d1, regData2: d2, pcs: pcs, regWrite: 1'b1, valid: 1'b1};
		issue(name, id, wb);
	endtask

	task automatic directedTests();
		isaPkg::memWbBus wb;
		// saturating add and sub
		directed("addPosSat", mkInstr(isaPkg::opAdd, 4'd1, 4'd2, 4'd3), 16'h7000, 16'h2000, 16'h0, noWb);
		directed("addNegSat", mkInstr(isaPkg::opAdd, 4'd1, 4'd2, 4'd3), 16'h8000, 16'hffff, 16'h0, noWb);
		directed("addPlain", mkInstr(isaPkg::opAdd, 4'd1, 4'd2, 4'd3), 16'h1234, 16'h0111, 16'h0, noWb);
		directed("subNegSat", mkInstr(isaPkg::opSub, 4'd1, 4'd2, 4'd3), 16'h8000, 16'h0001, 16'h0, noWb);
		directed("subPosSat", mkInstr(isaPkg::opSub, 4'd1, 4'd2, 4'd3), 16'h7fff, 16'hffff, 16'h0, noWb);
		// nibble lanes, red, xor
		directed("paddsbSat", mkInstr(isaPkg::opPaddsb, 4'd1, 4'd2, 4'd3), 16'h7788, 16'h11ff, 16'h0, noWb);
		directed("paddsbMix", mkInstr(isaPkg::opPaddsb, 4'd1, 4'd2, 4'd3), 16'h3a5c, 16'h2b6d, 16'h0, noWb);
		directed("redSum", mkInstr(isaPkg::opRed, 4'd1, 4'd2, 4'd3), 16'h7f80, 16'h0101, 16'h0, noWb);
		directed("xorOp", mkInstr(isaPkg::opXor, 4'd1, 4'd2, 4'd3), 16'ha5a5, 16'h0ff0, 16'h0, noWb);
		// shift amounts come from the immediate
		directed("sllImm", mkInstr(isaPkg::opSll, 4'd1, 4'd2, 4'd5), 16'h8001, 16'hdead, 16'h0, noWb);
		directed("sraImm", mkInstr(isaPkg::opSra, 4'd1, 4'd2, 4'd15), 16'h8000, 16'hdead, 16'h0, noWb);
		directed("rorImm", mkInstr(isaPkg::opRor, 4'd1, 4'd2, 4'd4), 16'h1234, 16'hdead, 16'h0, noWb);
		// memory offsets and byte loads
		directed("lwNeg", mkInstr(isaPkg::opLw, 4'd1, 4'd2, 4'hd), 16'h1000, 16'hffff, 16'h0, noWb);
		directed("swPos", mkInstr(isaPkg::opSw, 4'd1, 4'd2, 4'h7), 16'h2000, 16'hffff, 16'h0, noWb);
		directed("lhbByte", mkInstr(isaPkg::opLhb, 4'd3, 4'hc, 4'h5), 16'h1234, 16'h0, 16'h0, noWb);
		directed("llbByte", mkInstr(isaPkg::opLlb, 4'd3, 4'h9, 4'ha), 16'h1234, 16'h0, 16'h0, noWb);
		// pcs group ignores register data
		directed("pcsPass", mkInstr(isaPkg::opPcs, 4'd1, 4'd2, 4'd3), 16'hffff, 16'h7fff, 16'h0c40, noWb);
		directed("bPass", mkInstr(isaPkg::opB, 4'd1, 4'd2, 4'd3), 16'h1357, 16'h2468, 16'h8000, noWb);
		// forwarding
		directed("fwdProduce", mkInstr(isaPkg::opAdd, 4'd5, 4'd1, 4'd2), 16'h0100, 16'h0023, 16'h0, noWb);
		directed("fwdFromMem", mkInstr(isaPkg::opAdd, 4'd6, 4'd5, 4'd5), 16'hdead, 16'hbeef, 16'h0, noWb);
		wb = '{writeData: 16'h0400, rd: 4'd4, regWrite: 1'b1};
		directed("fwdFromWb", mkInstr(isaPkg::opXor, 4'd7, 4'd4, 4'd2), 16'hdead, 16'h0001, 16'h0, wb);
		directed("fwdProduce8", mkInstr(isaPkg::opAdd, 4'd8, 4'd1, 4'd2), 16'h0010, 16'h0001, 16'h0, noWb);
		wb.rd = 4'd8;
		directed("fwdMemWins", mkInstr(isaPkg::opAdd, 4'd9, 4'd8, 4'd3), 16'hdead, 16'h0001, 16'h0, wb);
		directed("lhbFromMem", mkInstr(isaPkg::opLhb, 4'd9, 4'h5, 4'h5), 16'hffff, 16'h0, 16'h0, noWb);
		directed("r0Produce", mkInstr(isaPkg::opAdd, 4'd0, 4'd1, 4'd2), 16'h1111, 16'h2222, 16'h0, noWb);
		wb.rd = 4'd0;
		directed("r0NoFwd", mkInstr(isaPkg::opAdd, 4'd1, 4'd0, 4'd0), 16'h0001, 16'h0002, 16'h0, wb);
	endtask

	task automatic randomStream();
		isaPkg::idExBus id;
		isaPkg::memWbBus wb;
		for (int i = 0; i < randCount; i++) begin
			id.instr[15:12] = 4'(takeBits(4));
			id.instr[11:8] = pickReg();
			id.instr[7:4] = pickReg();
			id.instr[3:0] = pickReg();
			id.regData1 = takeBits(16);
			id.regData2 = takeBits(16);
			id.pcs = takeBits(16);
			id.regWrite = 1'(takeBits(1));
			// about a quarter of the slots are bubbles
			id.valid = (takeBits(2) != 16'd0);
			wb.writeData = takeBits(16);
			wb.rd = pickReg();
			wb.regWrite = 1'(takeBits(1));
			issue($sformatf("random%0d", i), id, wb);
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		int guard;
		lfsrState = 32'ha68f_26ba;
		prevExp = '0;
		errCount = 0;
		rst = 1'b1;
		// a valid writing add sits on idEx for the whole reset
		idEx = '{instr: mkInstr(isaPkg::opAdd, 4'd1, 4'd2, 4'd3), regData1: 16'h1234,
			regData2: 16'h4321, pcs: 16'h0, regWrite: 1'b1, valid: 1'b1};
		memWb = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		idEx <= '0;
		// EX/MEM straight out of reset
		@(negedge clk);
		checkFlag("resetValid", 1'b0, exMem.valid);
		checkFlag("resetRegWrite", 1'b0, exMem.regWrite);
		checkWord("resetAluOut", 16'h0000, exMem.aluOut);
		directedTests();
		randomStream();
		guard = 0;
		while (expQ.size() != 0 && guard < drainLimit) begin
			@(negedge clk);
			guard++;
		end
		if (expQ.size() != 0) begin
			$display("%0d results never showed up on exMem", expQ.size());
			abortRun();
		end
		if (errCount == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			abortRun();
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
src/isaPkg.sv
src/aluPkg.sv
src/aluControl.sv
src/forwardUnit.sv
src/alu.sv
src/executeStage.sv
verification/executeStage_sva.sv
verification/executeStageTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module executeStageTb -o simv \
	|| { echo "run.sh: build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "run.sh: simulation ok" \
	|| { echo "run.sh: simulation failed"; exit 1; }
